//--- imul_array.f
hw/imul_pkg.sv
hw/mul_req_if.sv
hw/imul_apb_dispatch.sv
hw/imul_lane.sv
hw/imul_collect.sv
hw/imul_array.sv
sim/tb_clkgen.sv
sim/imul_array_asserts.sv
sim/imul_array_tb.sv

//--- sim/imul_vectors.txt
# columns: operand a, operand b, expected signed 64-bit product, all hex
# one case per line, lines starting with # are skipped
00000003 00000005 000000000000000f
fffffffd 00000005 fffffffffffffff1
00000007 fffffff9 ffffffffffffffcf
fffffff9 fffffff9 0000000000000031
00000000 12345678 0000000000000000
00000001 87654321 ffffffff87654321
80000000 00000001 ffffffff80000000
80000000 80000000 4000000000000000
80000000 ffffffff 0000000080000000
7fffffff 7fffffff 3fffffff00000001
ffffffff ffffffff 0000000000000001
00010000 00010000 0000000100000000
12345678 00000010 0000000123456780
ffff0000 00010000 ffffffff00000000
0000ffff 0000ffff 00000000fffe0001
80000000 7fffffff c000000080000000

//--- sim/imul_array_tb.sv
/* Runs the cases of sim/imul_vectors.txt through the APB port; start it from the
   project root. The case count should be a multiple of NUM_LANES. */

module imul_array_tb import imul_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LANES = 4;
  localparam int ADDR_W    = 8;

  logic              clk;
  logic              reset;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [OP_W-1:0]   pwdata;
  logic [OP_W-1:0]   prdata;
  logic              pready;
  logic              pslverr;

  // one entry per case from the vector file
  logic [OP_W-1:0]  vec_a [$];
  logic [OP_W-1:0]  vec_b [$];
  logic [RES_W-1:0] vec_p [$];

  int     errors = 0;
  int     cycles = 0;
  int     limit  = 32'h7fffffff;
  integer seed   = 32'h1c89;

  tb_clkgen u_clkgen (
    .clk   (clk),
    .reset (reset)
  );

  imul_array #(
    .NUM_LANES (NUM_LANES),
    .ADDR_W    (ADDR_W)
  ) u_imul_array (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always @(posedge clk) cycles <= cycles + 1;

  // ------------------------------------------------
  // checking and reporting
  // ------------------------------------------------
  task automatic check(input string name, input logic [RES_W-1:0] got,
                       input logic [RES_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("run complete, %0d error(s)", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  initial begin : watchdog
    wait (cycles >= limit);
    $display("timeout, the run did not complete within %0d clock cycles", limit);
    errors++;
    finish_run();
  end

  // ------------------------------------------------
  // APB access, entered and left 1 ns after a rising edge
  // ------------------------------------------------
  function automatic logic [ADDR_W-1:0] reg_addr(input int lane, input logic [OFS_W-1:0] ofs);
    return ADDR_W'(lane * LANE_STRIDE + ofs);
  endfunction

  task automatic apb_access(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [OP_W-1:0] data, output logic [OP_W-1:0] rdata,
                            output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1 penable = 1'b1;
    // mid access phase, all slave outputs settled
    #4;
    rdata = prdata;
    err   = pslverr;
    check("pready", pready, 1'b1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input int lane, input logic [OFS_W-1:0] ofs,
                           input logic [OP_W-1:0] data, input logic exp_err);
    logic [OP_W-1:0] rdata;
    logic            err;
    apb_access(1'b1, reg_addr(lane, ofs), data, rdata, err);
    check($sformatf("pslverr write lane %0d ofs %h", lane, ofs), err, exp_err);
  endtask

  task automatic read_reg(input int lane, input logic [OFS_W-1:0] ofs,
                          output logic [OP_W-1:0] data, input logic exp_err);
    logic err;
    apb_access(1'b0, reg_addr(lane, ofs), '0, data, err);
    check($sformatf("pslverr read lane %0d ofs %h", lane, ofs), err, exp_err);
  endtask

  // ------------------------------------------------
  // lane level steps
  // ------------------------------------------------
  task automatic load_operands(input int lane, input int idx);
    write_reg(lane, REG_OPA, vec_a[idx], 1'b0);
    write_reg(lane, REG_OPB, vec_b[idx], 1'b0);
  endtask

  // status word: bit 0 busy, bit 1 done
  task automatic check_status(input int lane, input logic busy, input logic done);
    logic [OP_W-1:0] sts;
    read_reg(lane, REG_CMD, sts, 1'b0);
    check($sformatf("prdata lane %0d status", lane), sts, {30'b0, done, busy});
  endtask

  task automatic wait_done(input int lane);
    logic [OP_W-1:0] sts;
    sts = '0;
    while (!sts[1]) begin
      read_reg(lane, REG_CMD, sts, 1'b0);
    end
  endtask

  // the high word read also frees the slot
  task automatic check_result(input int lane, input logic [RES_W-1:0] exp);
    logic [OP_W-1:0] lo;
    logic [OP_W-1:0] hi;
    read_reg(lane, REG_RES_LO, lo, 1'b0);
    read_reg(lane, REG_RES_HI, hi, 1'b0);
    check($sformatf("prdata lane %0d product", lane), {hi, lo}, exp);
  endtask

  task automatic load_vectors();
    int                      fd;
    int                      n;
    string                   line;
    logic [OP_W-1:0]         a;
    logic [OP_W-1:0]         b;
    logic [RES_W-1:0]        p;
    logic signed [RES_W-1:0] prod;
    fd = $fopen("sim/imul_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file sim/imul_vectors.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // nothing read at end of file, comment and blank lines scan as zero fields
      if (n > 0 && $sscanf(line, "%h %h %h", a, b, p) == 3) begin
        prod = $signed(a) * $signed(b);
        if (prod !== p) begin
          $display("vector file line for a=%h b=%h has a wrong product", a, b);
          errors++;
        end
        vec_a.push_back(a);
        vec_b.push_back(b);
        vec_p.push_back(p);
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------------------------
  // test sequence
  // ------------------------------------------------
  task automatic run_tests(input int nvec);
    int              perm [NUM_LANES];
    int              j;
    int              tmp;
    int              last;
    logic [OP_W-1:0] data;
    // reset state of every lane
    for (int l = 0; l < NUM_LANES; l++) begin
      check_status(l, 1'b0, 1'b0);
    end
    // one case at a time, lanes in turn
    for (int i = 0; i < nvec; i++) begin
      load_operands(i % NUM_LANES, i);
      write_reg(i % NUM_LANES, REG_CMD, 32'h1, 1'b0);
      wait_done(i % NUM_LANES);
      check_result(i % NUM_LANES, vec_p[i]);
    end
    // groups of NUM_LANES cases, started back to back in shuffled lane order
    for (int g = 0; g < nvec / NUM_LANES; g++) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        perm[k] = k;
      end
      for (int k = NUM_LANES - 1; k > 0; k--) begin
        j       = $unsigned($random(seed)) % (k + 1);
        tmp     = perm[k];
        perm[k] = perm[j];
        perm[j] = tmp;
      end
      for (int k = 0; k < NUM_LANES; k++) begin
        load_operands(perm[k], g * NUM_LANES + k);
      end
      for (int k = 0; k < NUM_LANES; k++) begin
        write_reg(perm[k], REG_CMD, 32'h1, 1'b0);
      end
      // all lanes should be mid calculation together
      for (int l = 0; l < NUM_LANES; l++) begin
        check_status(l, 1'b1, 1'b0);
      end
      for (int k = 0; k < NUM_LANES; k++) begin
        wait_done(perm[k]);
        check_result(perm[k], vec_p[g * NUM_LANES + k]);
      end
    end
    // start on a busy lane is refused and the running product survives
    last = nvec - 1;
    load_operands(0, last);
    write_reg(0, REG_CMD, 32'h1, 1'b0);
    write_reg(0, REG_OPA, ~vec_a[last], 1'b0);
    write_reg(0, REG_CMD, 32'h1, 1'b1);
    wait_done(0);
    check_result(0, vec_p[last]);
    // bus errors: unmapped offsets, read-only word, lane out of range
    read_reg(0, OFS_W'('h14), data, 1'b1);
    write_reg(0, OFS_W'('h1C), 32'h0, 1'b1);
    write_reg(0, REG_RES_LO, 32'h0, 1'b1);
    write_reg(NUM_LANES, REG_OPA, 32'h0, 1'b1);
    // unread result holds off the second one
    load_operands(NUM_LANES - 1, 0);
    write_reg(NUM_LANES - 1, REG_CMD, 32'h1, 1'b0);
    wait_done(NUM_LANES - 1);
    load_operands(NUM_LANES - 1, 1);
    write_reg(NUM_LANES - 1, REG_CMD, 32'h1, 1'b0);
    // 32 calc cycles and some margin, the lane then waits in done
    repeat (40) @(posedge clk);
    #1;
    check_status(NUM_LANES - 1, 1'b1, 1'b1);
    check_result(NUM_LANES - 1, vec_p[0]);
    check_status(NUM_LANES - 1, 1'b0, 1'b1);
    check_result(NUM_LANES - 1, vec_p[1]);
  endtask

  initial begin : main
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    load_vectors();
    limit = 200 * vec_p.size() + 500;
    @(negedge reset);
    if (vec_p.size() < NUM_LANES) begin
      $display("too few vectors loaded, need at least %0d", NUM_LANES);
      errors++;
    end else begin
      run_tests(vec_p.size());
    end
    finish_run();
  end

endmodule

//--- sim/imul_array_asserts.sv
/* Handshake checks for one multiplier lane, bound into every imul_lane.
   All checks are off while reset is high. */

module imul_array_asserts import imul_pkg::*; (
  input logic             clk,
  input logic             reset,
  input logic             req_val,
  input logic             req_rdy,
  input logic             idle,
  input logic             resp_val,
  input logic [RES_W-1:0] resp_result,
  input logic             resp_rdy
);
  timeunit 1ns;
  timeprecision 100ps;

  // a stalled response keeps valid high and its data frozen
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else $error("lane response dropped or changed before resp_rdy");

  // lane stays unavailable from acceptance up to the response transfer
  busy_until_resp: assert property (@(posedge clk) disable iff (reset)
    req_val && req_rdy |=> !req_rdy until_with (resp_val && resp_rdy))
    else $error("lane raised rdy before its response transferred");

  // requests only arrive while the lane sits in idle
  accept_in_idle: assert property (@(posedge clk) disable iff (reset)
    req_val |-> idle)
    else $error("request raised while the lane was not idle");

endmodule

bind imul_lane imul_array_asserts u_asserts (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req.val),
  .req_rdy     (req.rdy),
  .idle        (state == ST_IDLE),
  .resp_val    (resp_val),
  .resp_result (resp_result),
  .resp_rdy    (resp_rdy)
);

//--- sim/tb_clkgen.sv
/* Free-running clock and a synchronous reset held for RESET_CYCLES edges.
   Reset drops 1 ns after an edge, in step with the other DUT inputs. */

module tb_clkgen #(
  parameter real PERIOD       = 10.0,
  parameter int  RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

//--- hw/imul_array.sv
/* Multiply accelerator top: APB front end, NUM_LANES multiplier lanes and
   the result collector. Lane windows of 0x20 bytes must all fit in ADDR_W. */

module imul_array import imul_pkg::*; #(
  parameter int NUM_LANES = 4,
  parameter int ADDR_W    = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [OP_W-1:0]   pwdata,
  output logic [OP_W-1:0]   prdata,
  output logic              pready,
  output logic              pslverr
);

  localparam int LANE_W = lane_w(NUM_LANES);

  // request channels, dispatcher to lanes
  mul_req_if req [NUM_LANES] ();

  // response channels, lanes to collector
  logic [NUM_LANES-1:0] resp_val;
  logic [RES_W-1:0]     resp_result [NUM_LANES];
  logic [NUM_LANES-1:0] resp_rdy;

  // result read path
  logic [LANE_W-1:0]    rd_lane;
  logic                 rd_hi;
  logic                 rd_en;
  logic [OP_W-1:0]      rd_data;
  logic [NUM_LANES-1:0] done;

  imul_apb_dispatch #(
    .NUM_LANES (NUM_LANES),
    .ADDR_W    (ADDR_W)
  ) u_dispatch (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .req     (req),
    .rd_lane (rd_lane),
    .rd_hi   (rd_hi),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .done    (done)
  );

  // ------------------------------------------------
  // multiplier lanes
  // ------------------------------------------------
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    imul_lane u_lane (
      .clk         (clk),
      .reset       (reset),
      .req         (req[i]),
      .resp_val    (resp_val[i]),
      .resp_result (resp_result[i]),
      .resp_rdy    (resp_rdy[i])
    );
  end

  imul_collect #(
    .NUM_LANES (NUM_LANES)
  ) u_collect (
    .clk         (clk),
    .reset       (reset),
    .resp_val    (resp_val),
    .resp_result (resp_result),
    .resp_rdy    (resp_rdy),
    .rd_lane     (rd_lane),
    .rd_hi       (rd_hi),
    .rd_en       (rd_en),
    .rd_data     (rd_data),
    .done        (done)
  );

endmodule

//--- hw/imul_collect.sv
/* One 64-bit result slot per lane. A full slot holds off its lane until the
   high word is read; reading an empty slot returns stale data. */

module imul_collect import imul_pkg::*; #(
  parameter int NUM_LANES = 4,
  localparam int LANE_W   = lane_w(NUM_LANES)
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [NUM_LANES-1:0] resp_val,
  input  logic [RES_W-1:0]     resp_result [NUM_LANES],
  output logic [NUM_LANES-1:0] resp_rdy,
  input  logic [LANE_W-1:0]    rd_lane,
  input  logic                 rd_hi,
  input  logic                 rd_en,
  output logic [OP_W-1:0]      rd_data,
  output logic [NUM_LANES-1:0] done
);

  logic [RES_W-1:0]     slot [NUM_LANES];
  logic [NUM_LANES-1:0] full;
  logic [RES_W-1:0]     sel;

  // an empty slot takes the next response
  assign resp_rdy = ~full;
  assign done     = full;

  // ------------------------------------------------
  // slot flags
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= '0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (resp_val[i] && resp_rdy[i]) begin
          full[i] <= 1'b1;
        end else if (rd_en && rd_hi && (rd_lane == LANE_W'(i))) begin
          // high word read ends at this edge
          full[i] <= 1'b0;
        end
      end
    end
  end

  // result storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (resp_val[i] && resp_rdy[i]) begin
        slot[i] <= resp_result[i];
      end
    end
  end

  // read mux, same cycle as the APB access phase
  assign sel     = slot[rd_lane];
  assign rd_data = rd_hi ? sel[RES_W-1:OP_W] : sel[OP_W-1:0];

endmodule

//--- hw/imul_lane.sv
/* Iterative signed 32x32 multiplier, one partial product per cycle.
   Latency is 32 calc cycles; resp_val rises on the 33rd cycle after acceptance
   and the result stays held until the collector takes it. */

module imul_lane import imul_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  mul_req_if.lane          req,
  output logic             resp_val,
  output logic [RES_W-1:0] resp_result,
  input  logic             resp_rdy
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_DONE
  } state_t;

  state_t state;
  state_t state_next;

  // shift-and-add datapath
  logic [RES_W-1:0]  mcand;
  logic [OP_W-1:0]   mplier;
  logic [RES_W-1:0]  acc;
  logic [STEP_W-1:0] step;
  logic              neg;

  logic [OP_W-1:0] mag_a;
  logic [OP_W-1:0] mag_b;
  logic req_go;
  logic resp_go;
  logic last_step;

  // ------------------------------------------------
  // handshakes
  // ------------------------------------------------
  // only an idle lane takes new operands
  assign req.rdy   = (state == ST_IDLE);
  assign req_go    = req.val && req.rdy;
  assign resp_val  = (state == ST_DONE);
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (step == '0);

  // ------------------------------------------------
  // controller
  // ------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (req_go) begin
          state_next = ST_CALC;
        end
      end
      ST_CALC: begin
        // counter reached zero on this step
        if (last_step) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        // wait here while the slot is still full
        if (resp_go) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------------------------
  // datapath
  // ------------------------------------------------
  // operand magnitudes, 0x80000000 maps onto itself as unsigned
  assign mag_a = req.a[OP_W-1] ? (~req.a + 1'b1) : req.a;
  assign mag_b = req.b[OP_W-1] ? (~req.b + 1'b1) : req.b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand  <= {{(RES_W-OP_W){1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      // 31 down to 0 gives 32 steps
      step   <= STEP_W'(OP_W - 1);
      // product negative when exactly one operand is
      neg    <= req.a[OP_W-1] ^ req.b[OP_W-1];
    end else if (state == ST_CALC) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      step   <= step - 1'b1;
    end
  end

  // sign fix-up, acc is frozen in done so this stays stable
  assign resp_result = neg ? (~acc + 1'b1) : acc;

endmodule

//--- hw/imul_apb_dispatch.sv
/* APB slave front end, no wait states and no byte strobes.
   val is raised only in the access phase of a start write that finds the lane idle,
   so each launch transfers in that same cycle. */

module imul_apb_dispatch import imul_pkg::*; #(
  parameter int NUM_LANES = 4,
  parameter int ADDR_W    = 8,
  localparam int LANE_W   = lane_w(NUM_LANES)
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [OP_W-1:0]   pwdata,
  output logic [OP_W-1:0]   prdata,
  output logic              pready,
  output logic              pslverr,
  mul_req_if.dispatcher     req [NUM_LANES],
  output logic [LANE_W-1:0] rd_lane,
  output logic              rd_hi,
  output logic              rd_en,
  input  logic [OP_W-1:0]   rd_data,
  input  logic [NUM_LANES-1:0] done
);

  logic [OP_W-1:0] op_a [NUM_LANES];
  logic [OP_W-1:0] op_b [NUM_LANES];
  logic [NUM_LANES-1:0] lane_rdy;
  logic [ADDR_W-OFS_W-1:0] lane_fld;
  logic [OFS_W-1:0] ofs;
  logic [LANE_W-1:0] lane;
  logic access, wr, rd;
  logic lane_ok, mapped, ro_reg;
  logic start, launch;
  lane_sts_t sts;

  // ------------------------------------------------
  // address decode
  // ------------------------------------------------
  assign access   = psel && penable;
  assign wr       = access && pwrite;
  assign rd       = access && !pwrite;
  // upper bits pick the lane, lower bits the register
  assign lane_fld = paddr[ADDR_W-1:OFS_W];
  assign ofs      = paddr[OFS_W-1:0];
  assign lane     = lane_fld[LANE_W-1:0];
  assign lane_ok  = (lane_fld < NUM_LANES);
  assign ro_reg   = (ofs == REG_RES_LO) || (ofs == REG_RES_HI);
  assign mapped   = lane_ok && ((ofs == REG_OPA) || (ofs == REG_OPB) ||
                                (ofs == REG_CMD) || ro_reg);

  // start request, only bit 0 of the command word matters
  assign start  = wr && mapped && (ofs == REG_CMD) && pwdata[0];
  assign launch = start && lane_rdy[lane];

  // no wait states at all
  assign pready  = 1'b1;
  // unmapped, write to result word, or start on a busy lane
  assign pslverr = access && (!mapped || (pwrite && ro_reg) || (start && !lane_rdy[lane]));

  // ------------------------------------------------
  // per lane request channel
  // ------------------------------------------------
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_req
    assign lane_rdy[i] = req[i].rdy;
    assign req[i].val  = launch && (lane == LANE_W'(i));
    assign req[i].a    = op_a[i];
    assign req[i].b    = op_b[i];
  end

  // operand registers, loaded by plain writes
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        op_a[i] <= '0;
        op_b[i] <= '0;
      end
    end else if (wr && mapped) begin
      if (ofs == REG_OPA) begin
        op_a[lane] <= pwdata;
      end
      if (ofs == REG_OPB) begin
        op_b[lane] <= pwdata;
      end
    end
  end

  // ------------------------------------------------
  // read path
  // ------------------------------------------------
  // busy tracks the lane, done tracks the result slot
  assign sts.busy = !lane_rdy[lane];
  assign sts.done = done[lane];

  // result words come straight from the collector
  assign rd_lane = lane;
  assign rd_hi   = (ofs == REG_RES_HI);
  assign rd_en   = rd && mapped && ro_reg;

  always_comb begin
    prdata = '0;
    if (rd && lane_ok) begin
      case (ofs)
        REG_OPA:                prdata = op_a[lane];
        REG_OPB:                prdata = op_b[lane];
        REG_CMD:                prdata = OP_W'(sts);
        REG_RES_LO, REG_RES_HI: prdata = rd_data;
        default:                prdata = '0;
      endcase
    end
  end

endmodule

//--- hw/mul_req_if.sv
/* Operand request channel of one lane, val/rdy handshake.
   A transfer happens on an edge with val and rdy both high. */

interface mul_req_if import imul_pkg::*; ();

  // request valid, from the dispatcher
  logic val;
  // lane idle and able to take operands
  logic rdy;
  // signed operands
  logic [OP_W-1:0] a;
  logic [OP_W-1:0] b;

  modport dispatcher (
    output val, a, b,
    input  rdy
  );

  modport lane (
    input  val, a, b,
    output rdy
  );

endinterface

//--- hw/imul_pkg.sv
/* Shared widths, register map and status encoding for the multiply array.
   Each lane owns a LANE_STRIDE window; offsets above REG_RES_HI are unmapped. */

package imul_pkg;

  // datapath widths
  localparam int OP_W   = 32;
  localparam int RES_W  = 64;
  localparam int STEP_W = 5;

  // ------------------------------------------------
  // address map, one window per lane
  // ------------------------------------------------
  localparam int unsigned LANE_STRIDE = 'h20;
  localparam int OFS_W = $clog2(LANE_STRIDE);

  localparam logic [OFS_W-1:0] REG_OPA    = 'h00;
  localparam logic [OFS_W-1:0] REG_OPB    = 'h04;
  // write bit 0 starts, read bit 0 busy, bit 1 done
  localparam logic [OFS_W-1:0] REG_CMD    = 'h08;
  localparam logic [OFS_W-1:0] REG_RES_LO = 'h0C;
  // reading this one frees the result slot
  localparam logic [OFS_W-1:0] REG_RES_HI = 'h10;

  // status word, busy lands in bit 0
  typedef struct packed {
    logic done;
    logic busy;
  } lane_sts_t;

  // lane select width, never below one bit
  function automatic int lane_w(int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage
